// File: activity_leds.sv
/*
  Activity LEDs that stay lit long enough to be seen.
  An LED lights the cycle after its act bit and stays on for stretch_len
  cycles after act was last seen high. stretch_len of 0 gives the raw activity.
  A new stretch_len applies from the next reload of each channel.
*/
`timescale 1ns/100ps

module activity_leds (
    input  logic                           clk,
    input  logic                           sys_reset,
    input  logic [fpgc_pkg::ACT_CH-1:0]    act,
    input  logic [fpgc_pkg::STRETCH_W-1:0] stretch_len,
    output logic [fpgc_pkg::ACT_CH-1:0]    leds
);
    import fpgc_pkg::*;

    // Activity seen last cycle, one bit per channel
    logic [ACT_CH-1:0]    act_q;
    logic [STRETCH_W-1:0] hold_cnt [ACT_CH];

    always_ff @(posedge clk) begin
        if (sys_reset) begin
            act_q <= '0;
            for (int i = 0; i < ACT_CH; i++) begin
                hold_cnt[i] <= '0;
            end
        end else begin
            act_q <= act;
            for (int i = 0; i < ACT_CH; i++) begin
                if (act[i]) begin
                    hold_cnt[i] <= stretch_len;
                end else if (!act_q[i] && hold_cnt[i] != '0) begin
                    // Count starts once the registered activity has gone
                    hold_cnt[i] <= hold_cnt[i] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < ACT_CH; i++) begin
            leds[i] = act_q[i] | (hold_cnt[i] != '0);
        end
    end

endmodule

// File: flist.f
fpgc_pkg.sv
input_stabilizer.sv
reset_gen.sv
activity_leds.sv
sysctl_regs.sv
fpgc_sysctl.sv
fpgc_sysctl_assert.sv
tb_clock.sv
tb_fpgc_sysctl.sv

// File: fpgc_pkg.sv
/*
  Shared constants and types for the FPGC6 system control block.
  One clock domain. Every board input is asynchronous and goes through the stabilizer.
  The register port answers every request in exactly one cycle and has no back-pressure.
*/
package fpgc_pkg;

    // Stabilizer depth per asynchronous input
    localparam int SYNC_STAGES = 2;

    localparam int GPI_W = 4;
    localparam int GPO_W = 4;
    localparam int SPI_IRQ_N = 4;

    // USB0, USB1, Eth, PS2, Flash
    localparam int ACT_CH = 5;

    // DTR reset pulse length and the counter that times it
    localparam int DTR_PULSE_CYCLES = 8;
    localparam int DTR_CNT_W = $clog2(DTR_PULSE_CYCLES);

    localparam int STRETCH_W = 16;
    localparam logic [STRETCH_W-1:0] LED_STRETCH_DEFAULT = 16'd16;

    localparam int REG_ADDR_W = 2;
    localparam int BUS_DATA_W = 32;

    // Reads back as ASCII "FPGC"
    localparam logic [BUS_DATA_W-1:0] SYSCTL_ID = 32'h4650_4743;

    // Boot LED position in REG_LEDCFG, above the stretch field
    localparam int LEDCFG_BOOT_BIT = 16;

    // Width of the stabilized input struct
    localparam int ASYNC_W = 1 + SPI_IRQ_N + GPI_W + 1;

    typedef enum logic [REG_ADDR_W-1:0] {
        REG_ID     = 2'd0,
        REG_INPUTS = 2'd1,
        REG_GPO    = 2'd2,
        REG_LEDCFG = 2'd3
    } reg_addr_e;

    typedef enum logic {
        BUS_READ  = 1'b0,
        BUS_WRITE = 1'b1
    } bus_op_e;

    typedef struct packed {
        bus_op_e                 op;
        reg_addr_e               addr;
        logic [BUS_DATA_W-1:0]   wdata;
    } bus_req_t;

    typedef struct packed {
        logic                    done;
        logic [BUS_DATA_W-1:0]   rdata;
    } bus_rsp_t;

    // Raw board inputs and their stabilized copies, boot_mode is DIP switch 0
    typedef struct packed {
        logic                    dtr;
        logic [SPI_IRQ_N-1:0]    spi_irq;
        logic [GPI_W-1:0]        gpi;
        logic                    boot_mode;
    } async_in_t;

    // USB chips take an active-high reset, Ethernet an active-low one
    typedef struct packed {
        logic                    usb0_rst;
        logic                    usb1_rst;
        logic                    eth_nrst;
    } ext_reset_t;

    typedef enum logic [1:0] {
        DTR_IDLE,
        DTR_PULSE,
        DTR_WAIT_LOW
    } dtr_state_e;

endpackage

// File: fpgc_sysctl.sv
/*
  FPGC6 board-level system control: input stabilizers, DTR reset,
  CPU register block and status LEDs.
  Stabilizer and reset generator run from board reset. Everything else
  is also cleared by the DTR pulse. A raw DTR rise reaches sys_reset in 3 cycles.
*/
`timescale 1ns/100ps

module fpgc_sysctl (
    input  logic                           clk,
    input  logic                           reset,
    input  fpgc_pkg::async_in_t            raw_in,
    input  logic [fpgc_pkg::ACT_CH-1:0]    act,
    input  logic                           bus_start,
    input  fpgc_pkg::bus_req_t             bus_req,
    output fpgc_pkg::bus_rsp_t             bus_rsp,
    output logic                           sys_reset,
    output fpgc_pkg::ext_reset_t           ext_rst,
    output logic [fpgc_pkg::GPO_W-1:0]     gpo,
    output logic [fpgc_pkg::ACT_CH-1:0]    leds,
    output logic                           led_booted
);
    import fpgc_pkg::*;

    async_in_t            stable;
    logic [STRETCH_W-1:0] stretch_len;

    input_stabilizer u_stabilizer (
        .clk    (clk),
        .reset  (reset),
        .raw_in (raw_in),
        .stable (stable)
    );

    reset_gen u_reset_gen (
        .clk       (clk),
        .reset     (reset),
        .dtr       (stable.dtr),
        .sys_reset (sys_reset),
        .ext_rst   (ext_rst)
    );

    sysctl_regs u_regs (
        .clk         (clk),
        .sys_reset   (sys_reset),
        .bus_start   (bus_start),
        .bus_req     (bus_req),
        .bus_rsp     (bus_rsp),
        .inputs      (stable),
        .gpo         (gpo),
        .led_booted  (led_booted),
        .stretch_len (stretch_len)
    );

    // Channel order USB0, USB1, Eth, PS2, Flash
    activity_leds u_leds (
        .clk         (clk),
        .sys_reset   (sys_reset),
        .act         (act),
        .stretch_len (stretch_len),
        .leds        (leds)
    );

endmodule

// File: fpgc_sysctl_assert.sv
/*
  Concurrent checks for fpgc_sysctl, bound into every instance.
  Expected DTR pulse, register and LED values come from small reference models here.
  fail_count counts failed checks so the testbench can stop the run.
*/
`timescale 1ns/100ps

module fpgc_sysctl_assert (
    input logic                           clk,
    input logic                           reset,
    input fpgc_pkg::async_in_t            raw_in,
    input logic [fpgc_pkg::ACT_CH-1:0]    act,
    input logic                           bus_start,
    input fpgc_pkg::bus_req_t             bus_req,
    input fpgc_pkg::bus_rsp_t             bus_rsp,
    input logic                           sys_reset,
    input fpgc_pkg::ext_reset_t           ext_rst,
    input logic [fpgc_pkg::GPO_W-1:0]     gpo,
    input logic [fpgc_pkg::ACT_CH-1:0]    leds,
    input logic                           led_booted,
    input logic [fpgc_pkg::STRETCH_W-1:0] stretch_len
);
    import fpgc_pkg::*;

    int          fail_count = 0;
    logic [1:0]  dtr_hist;
    logic        armed;
    logic [3:0]  pulse_left;
    logic [16:0] age [ACT_CH];
    logic [ACT_CH-1:0] exp_leds;
    logic [GPO_W-1:0]  gpo_model;
    logic [16:0]       ledcfg_model;

    // DTR reaches the reset logic two edges late, one pulse per rise
    always_ff @(posedge clk) begin
        if (reset) begin
            dtr_hist   <= 2'b00;
            armed      <= 1'b1;
            pulse_left <= 4'd0;
        end else begin
            dtr_hist <= {dtr_hist[0], raw_in.dtr};
            if (armed && dtr_hist[1]) begin
                pulse_left <= 4'(DTR_PULSE_CYCLES);
                armed      <= 1'b0;
            end else if (pulse_left != 4'd0) begin
                pulse_left <= pulse_left - 4'd1;
            end else if (!dtr_hist[1]) begin
                armed <= 1'b1;
            end
        end
    end

    // Register contents as written over the bus, cleared by any reset
    always_ff @(posedge clk) begin
        if (sys_reset) begin
            gpo_model    <= '0;
            ledcfg_model <= {1'b0, LED_STRETCH_DEFAULT};
        end else if (bus_start && bus_req.op == BUS_WRITE) begin
            if (bus_req.addr == REG_GPO) begin
                gpo_model <= bus_req.wdata[GPO_W-1:0];
            end else if (bus_req.addr == REG_LEDCFG) begin
                ledcfg_model <= bus_req.wdata[16:0];
            end
        end
    end

    // Cycles since each act bit was last high, saturating
    always_ff @(posedge clk) begin
        for (int i = 0; i < ACT_CH; i++) begin
            if (sys_reset) begin
                age[i] <= '1;
            end else if (act[i]) begin
                age[i] <= '0;
            end else if (age[i] != '1) begin
                age[i] <= age[i] + 17'd1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < ACT_CH; i++) begin
            exp_leds[i] = (age[i] <= {1'b0, stretch_len});
        end
    end

    a_sys_reset: assert property (@(posedge clk)
        sys_reset == (reset || (pulse_left != 4'd0)))
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t sys_reset exp=%b got=%b", $time,
                   reset || (pulse_left != 4'd0), sys_reset);
        end

    a_ext_rst: assert property (@(posedge clk)
        ext_rst == {sys_reset, sys_reset, ~sys_reset})
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t ext_rst exp=%b got=%b", $time,
                   {sys_reset, sys_reset, ~sys_reset}, ext_rst);
        end

    a_done_idle: assert property (@(posedge clk) sys_reset || !bus_start |=> !bus_rsp.done)
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t bus_rsp.done exp=0 got=%b", $time, bus_rsp.done);
        end

    a_done_hit: assert property (@(posedge clk) disable iff (sys_reset)
        bus_start |=> bus_rsp.done)
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t bus_rsp.done exp=1 got=%b", $time, bus_rsp.done);
        end

    a_read_id: assert property (@(posedge clk) disable iff (sys_reset)
        bus_start && bus_req.op == BUS_READ && bus_req.addr == REG_ID
        |=> bus_rsp.rdata == SYSCTL_ID)
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t rdata exp=%h got=%h", $time, SYSCTL_ID,
                   bus_rsp.rdata);
        end

    a_read_gpo: assert property (@(posedge clk) disable iff (sys_reset)
        bus_start && bus_req.op == BUS_READ && bus_req.addr == REG_GPO
        |=> bus_rsp.rdata == {28'd0, $past(gpo_model)})
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t rdata exp=%h got=%h", $time,
                   {28'd0, $past(gpo_model)}, bus_rsp.rdata);
        end

    a_read_ledcfg: assert property (@(posedge clk) disable iff (sys_reset)
        bus_start && bus_req.op == BUS_READ && bus_req.addr == REG_LEDCFG
        |=> bus_rsp.rdata == {15'd0, $past(ledcfg_model)})
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t rdata exp=%h got=%h", $time,
                   {15'd0, $past(ledcfg_model)}, bus_rsp.rdata);
        end

    // Stable copy of raw_in is two edges old when the read is decoded
    a_read_inputs: assert property (@(posedge clk) disable iff (sys_reset)
        bus_start && bus_req.op == BUS_READ && bus_req.addr == REG_INPUTS
        |=> bus_rsp.rdata == {22'd0, $past(raw_in, 3)})
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t rdata exp=%h got=%h", $time,
                   {22'd0, $past(raw_in, 3)}, bus_rsp.rdata);
        end

    a_write_gpo: assert property (@(posedge clk) disable iff (sys_reset)
        bus_start && bus_req.op == BUS_WRITE && bus_req.addr == REG_GPO
        |=> gpo == $past(bus_req.wdata[GPO_W-1:0]))
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t gpo exp=%h got=%h", $time,
                   $past(bus_req.wdata[GPO_W-1:0]), gpo);
        end

    a_write_ledcfg: assert property (@(posedge clk) disable iff (sys_reset)
        bus_start && bus_req.op == BUS_WRITE && bus_req.addr == REG_LEDCFG
        |=> {led_booted, stretch_len} == $past(bus_req.wdata[16:0]))
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t ledcfg exp=%h got=%h", $time,
                   $past(bus_req.wdata[16:0]), {led_booted, stretch_len});
        end

    a_after_reset: assert property (@(posedge clk) $fell(sys_reset)
        |-> gpo == '0 && !led_booted && leds == '0 && stretch_len == LED_STRETCH_DEFAULT)
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t gpo/boot/leds/stretch exp=0/0/0/%0d got=%h/%b/%b/%0d",
                   $time, LED_STRETCH_DEFAULT, gpo, led_booted, leds, stretch_len);
        end

    a_leds: assert property (@(posedge clk) disable iff (sys_reset) leds == exp_leds)
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t leds exp=%b got=%b", $time, exp_leds, leds);
        end

endmodule

bind fpgc_sysctl fpgc_sysctl_assert u_assert (.*);

// File: input_stabilizer.sv
/*
  Flop chain stabilizer for all asynchronous board inputs.
  Each bit is synchronized on its own, so a multi-bit field such as gpi
  may be seen mid-change for one cycle. Hold inputs steady when reading them.
*/
`timescale 1ns/100ps

module input_stabilizer (
    input  logic                clk,
    input  logic                reset,
    input  fpgc_pkg::async_in_t raw_in,
    output fpgc_pkg::async_in_t stable
);
    import fpgc_pkg::*;

    async_in_t sync_q [SYNC_STAGES];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            // First stage may go metastable, later stages settle it
            sync_q[0] <= raw_in;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign stable = sync_q[SYNC_STAGES-1];

endmodule

// File: reset_gen.sv
/*
  Turns a rising edge of the stabilized DTR line into a fixed reset pulse.
  A second pulse needs DTR to drop first, so an open serial port resets once.
  Board reset passes through combinationally. Drive this block from board reset only.
*/
`timescale 1ns/100ps

module reset_gen (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dtr,
    output logic                 sys_reset,
    output fpgc_pkg::ext_reset_t ext_rst
);
    import fpgc_pkg::*;

    dtr_state_e           state;
    logic [DTR_CNT_W-1:0] pulse_cnt;
    logic                 dtr_rst;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= DTR_IDLE;
            pulse_cnt <= '0;
        end else begin
            case (state)
                // DTR has been seen low, so a high level here is a rising edge
                DTR_IDLE: begin
                    pulse_cnt <= '0;
                    if (dtr) begin
                        state <= DTR_PULSE;
                    end
                end
                DTR_PULSE: begin
                    pulse_cnt <= pulse_cnt + 1'b1;
                    if (pulse_cnt == DTR_CNT_W'(DTR_PULSE_CYCLES - 1)) begin
                        state <= DTR_WAIT_LOW;
                    end
                end
                // No re-arm while DTR stays high
                DTR_WAIT_LOW: begin
                    if (!dtr) begin
                        state <= DTR_IDLE;
                    end
                end
                default: begin
                    state <= DTR_IDLE;
                end
            endcase
        end
    end

    assign dtr_rst   = (state == DTR_PULSE);
    assign sys_reset = reset | dtr_rst;

    // External chips follow the combined reset
    assign ext_rst.usb0_rst = sys_reset;
    assign ext_rst.usb1_rst = sys_reset;
    assign ext_rst.eth_nrst = ~sys_reset;

endmodule

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only on the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_fpgc_sysctl -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx ">>> PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: sysctl_regs.sv
/*
  CPU-visible system control registers on a start/done bus.
  Every access completes in one cycle, done is high the cycle after bus_start.
  Writes to REG_ID and REG_INPUTS are dropped. Unused read bits are zero.
  Map: 0 ID, 1 stabilized inputs, 2 GPO, 3 LED stretch in 15:0 and boot LED in 16.
*/
`timescale 1ns/100ps

module sysctl_regs (
    input  logic                           clk,
    input  logic                           sys_reset,
    input  logic                           bus_start,
    input  fpgc_pkg::bus_req_t             bus_req,
    output fpgc_pkg::bus_rsp_t             bus_rsp,
    input  fpgc_pkg::async_in_t            inputs,
    output logic [fpgc_pkg::GPO_W-1:0]     gpo,
    output logic                           led_booted,
    output logic [fpgc_pkg::STRETCH_W-1:0] stretch_len
);
    import fpgc_pkg::*;

    logic                  done_q;
    logic [BUS_DATA_W-1:0] rdata_q;
    logic [BUS_DATA_W-1:0] rd_mux;
    logic                  wr_en;

    assign wr_en = bus_start && (bus_req.op == BUS_WRITE);

    // Read value for the addressed register
    always_comb begin
        rd_mux = '0;
        case (bus_req.addr)
            REG_ID: begin
                rd_mux = SYSCTL_ID;
            end
            REG_INPUTS: begin
                rd_mux[ASYNC_W-1:0] = inputs;
            end
            REG_GPO: begin
                rd_mux[GPO_W-1:0] = gpo;
            end
            REG_LEDCFG: begin
                rd_mux[STRETCH_W-1:0]   = stretch_len;
                rd_mux[LEDCFG_BOOT_BIT] = led_booted;
            end
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    // Bus response, done only for the cycle after a start
    always_ff @(posedge clk) begin
        if (sys_reset) begin
            done_q <= 1'b0;
        end else begin
            done_q <= bus_start;
        end
    end

    always_ff @(posedge clk) begin
        if (bus_start) begin
            rdata_q <= rd_mux;
        end
    end

    // Writable registers, updated on the start cycle so they show with done
    always_ff @(posedge clk) begin
        if (sys_reset) begin
            gpo         <= '0;
            led_booted  <= 1'b0;
            stretch_len <= LED_STRETCH_DEFAULT;
        end else if (wr_en) begin
            case (bus_req.addr)
                REG_GPO: begin
                    gpo <= bus_req.wdata[GPO_W-1:0];
                end
                REG_LEDCFG: begin
                    stretch_len <= bus_req.wdata[STRETCH_W-1:0];
                    led_booted  <= bus_req.wdata[LEDCFG_BOOT_BIT];
                end
                default: begin
                    // ID and inputs are read only
                end
            endcase
        end
    end

    assign bus_rsp.done  = done_q;
    assign bus_rsp.rdata = rdata_q;

endmodule

// File: tb_clock.sv
/*
  Testbench clock and board reset.
  40 ns period. Reset is high for the first 2 rising edges and drops on a falling edge.
*/
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: tb_fpgc_sysctl.sv
/*
  Testbench for fpgc_sysctl. Inputs change on the falling clock edge.
  The bound assertions do the checking, this module only steers the DUT
  through reset, bus, stabilizer, DTR and LED scenarios and ends the run.
*/
`timescale 1ns/100ps

module tb_fpgc_sysctl;
    import fpgc_pkg::*;

    localparam int MAX_CYCLES = 2000;

    logic                 clk;
    logic                 reset;
    async_in_t            raw_in;
    logic [ACT_CH-1:0]    act;
    logic                 bus_start;
    bus_req_t             bus_req;
    bus_rsp_t             bus_rsp;
    logic                 sys_reset;
    ext_reset_t           ext_rst;
    logic [GPO_W-1:0]     gpo;
    logic [ACT_CH-1:0]    leds;
    logic                 led_booted;
    int                   cycles;

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    fpgc_sysctl dut (
        .clk        (clk),
        .reset      (reset),
        .raw_in     (raw_in),
        .act        (act),
        .bus_start  (bus_start),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .sys_reset  (sys_reset),
        .ext_rst    (ext_rst),
        .gpo        (gpo),
        .leds       (leds),
        .led_booted (led_booted)
    );

    // One access, then wait for done
    task automatic bus_access(input bus_op_e op, input reg_addr_e addr,
                              input logic [31:0] wdata);
        bus_start     = 1'b1;
        bus_req.op    = op;
        bus_req.addr  = addr;
        bus_req.wdata = wdata;
        @(negedge clk);
        bus_start = 1'b0;
        while (!bus_rsp.done) begin
            @(negedge clk);
        end
    endtask

    task automatic bus_write(input reg_addr_e addr, input logic [31:0] wdata);
        bus_access(BUS_WRITE, addr, wdata);
    endtask

    task automatic bus_read(input reg_addr_e addr);
        bus_access(BUS_READ, addr, 32'd0);
    endtask

    task automatic wait_dtr_pulse();
        while (!sys_reset) begin
            @(negedge clk);
        end
        while (sys_reset) begin
            @(negedge clk);
        end
    endtask

    task automatic pulse_act(input int ch);
        act[ch] = 1'b1;
        @(negedge clk);
        act[ch] = 1'b0;
        repeat (8) @(negedge clk);
    endtask

    // Stop at the first failed check
    always @(posedge clk) begin
        if (dut.u_assert.fail_count != 0) begin
            $display(">>> FAIL");
            $fatal(1, "A DUT check failed, see the error above");
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "Simulation timed out");
        end
    end

    initial begin
        logic [31:0] rnd;

        cycles    = 0;
        raw_in    = '0;
        act       = '0;
        bus_start = 1'b0;
        bus_req   = '0;
        rnd       = $urandom(32'hcf7bbde3);

        @(negedge clk);
        while (reset || sys_reset) begin
            @(negedge clk);
        end
        @(negedge clk);

        // Bus timing, ID and GPO
        bus_read(REG_ID);
        bus_write(REG_GPO, 32'h0000_000a);
        bus_read(REG_GPO);
        bus_write(REG_ID, 32'h1234_5678);
        bus_read(REG_ID);

        // Stabilized inputs, dtr stays low
        for (int i = 0; i < 6; i++) begin
            rnd = $urandom;
            raw_in.gpi       = rnd[3:0];
            raw_in.spi_irq   = rnd[7:4];
            raw_in.boot_mode = rnd[8];
            repeat (3) @(negedge clk);
            bus_read(REG_INPUTS);
        end

        // DTR reset clears the registers
        bus_write(REG_GPO, 32'h0000_0005);
        bus_write(REG_LEDCFG, 32'h0001_0007);
        raw_in.dtr = 1'b1;
        wait_dtr_pulse();
        @(negedge clk);
        bus_read(REG_GPO);
        bus_read(REG_LEDCFG);

        // Held high, so no second pulse
        repeat (20) @(negedge clk);
        raw_in.dtr = 1'b0;
        repeat (4) @(negedge clk);
        raw_in.dtr = 1'b1;
        wait_dtr_pulse();
        raw_in.dtr = 1'b0;
        repeat (4) @(negedge clk);

        // LED stretch of 4 with the boot LED on
        bus_write(REG_LEDCFG, 32'h0001_0004);
        for (int ch = 0; ch < ACT_CH; ch++) begin
            pulse_act(ch);
        end
        bus_read(REG_LEDCFG);
        bus_write(REG_LEDCFG, 32'h0000_0004);
        pulse_act(2);

        repeat (4) @(negedge clk);
        if (dut.u_assert.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1, "DUT checks failed");
        end
    end

endmodule
